//--- Bender.yml
package:
  name: lcd_ctrl

sources:
  - include_dirs:
      - include
    files:
      - hw/lcd_pkg.sv
      - hw/lcd_cmd_fifo.sv
      - hw/lcd_wb_regs.sv
      - hw/lcd_engine.sv
      - hw/lcd_top.sv
      - target: test
        files:
          - tests/lcd_pin_checker.sv
          - tests/tb_lcd.sv

//--- build.f
+incdir+include
hw/lcd_pkg.sv
hw/lcd_cmd_fifo.sv
hw/lcd_wb_regs.sv
hw/lcd_engine.sv
hw/lcd_top.sv
tests/lcd_pin_checker.sv
tests/tb_lcd.sv

//--- hw/lcd_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_cmd_fifo (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     push,
	input  lcd_pkg::lcd_word_t       push_word,
	input  logic                     pop,
	output lcd_pkg::lcd_word_t       head,
	output logic                     valid,
	output logic                     full,
	output logic [`LCD_LVL_BITS-1:0] level
);
	import lcd_pkg::*;

	localparam int DEPTH = `LCD_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	lcd_word_t   mem [DEPTH];
	logic [AW:0] wr_ptr;      // msb is the wrap bit
	logic [AW:0] rd_ptr;

	assign level = wr_ptr - rd_ptr;
	assign valid = (wr_ptr != rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign head  = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= push_word;   // head next cycle when empty
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> valid);

	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> !full);

endmodule

`default_nettype wire

//--- hw/lcd_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_engine (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::lcd_opts_t opts,
	input  logic               init_start,
	input  logic               cmd_valid,
	input  lcd_pkg::lcd_word_t cmd_word,
	output logic               cmd_pop,
	output logic               init_done,
	output logic               busy,
	output lcd_pkg::lcd_pins_t pins
);
	import lcd_pkg::*;

	localparam int unsigned U        = `LCD_CLK_PER_US;
	localparam int unsigned XFER_LEN = 50 * U;

	typedef logic [`LCD_CNT_BITS-1:0] cnt_t;

	localparam cnt_t T_PWR_END  = cnt_t'(500 * U - 1);
	localparam cnt_t T_INIT_END = cnt_t'(440 * U - 1);
	localparam cnt_t T_XFER_END = cnt_t'(XFER_LEN - 1);
	localparam cnt_t T_FS_END   = cnt_t'(10 * U);    // function set strobe
	localparam cnt_t T_DC_BEG   = cnt_t'(60 * U);
	localparam cnt_t T_DC_END   = cnt_t'(70 * U);
	localparam cnt_t T_CLR_BEG  = cnt_t'(120 * U);
	localparam cnt_t T_CLR_END  = cnt_t'(130 * U);
	localparam cnt_t T_EM_BEG   = cnt_t'(330 * U);
	localparam cnt_t T_EM_END   = cnt_t'(340 * U);
	localparam cnt_t T_E_RISE   = cnt_t'(U);         // address setup
	localparam cnt_t T_E_FALL   = cnt_t'(14 * U);
	localparam cnt_t T_HOLD_END = cnt_t'(27 * U);

	typedef enum logic [1:0] {
		ST_PWRUP,
		ST_INIT,
		ST_IDLE,
		ST_XFER
	} state_t;

	state_t    state_q, state_d;
	cnt_t      cnt_q, cnt_d;
	logic      armed_q, armed_d;       // power-up delay running
	lcd_word_t word_q, word_d;
	lcd_pins_t pins_d;

	// pin image for a given point of the sequence
	function automatic lcd_pins_t decode(state_t st, cnt_t cnt, lcd_opts_t op,
		lcd_word_t w);
		lcd_pins_t p;
		p = '0;
		case (st)
			ST_INIT: begin
				if (cnt < T_FS_END) begin
					p.e    = 1'b1;
					p.data = {4'b0011, op.lines, op.font, 2'b00};
				end else if (cnt >= T_DC_BEG && cnt < T_DC_END) begin
					p.e    = 1'b1;
					p.data = {5'b00001, op.disp_on, op.cursor, op.blink};
				end else if (cnt >= T_CLR_BEG && cnt < T_CLR_END) begin
					p.e    = 1'b1;
					p.data = 8'h01;
				end else if (cnt >= T_EM_BEG && cnt < T_EM_END) begin
					p.e    = 1'b1;
					p.data = {6'b000001, op.inc, op.shift};
				end
			end
			ST_XFER: begin
				if (cnt < T_HOLD_END) begin     // setup, strobe and hold
					p.rs   = w.rs;
					p.rw   = w.rw;
					p.data = w.data;
					p.e    = (cnt >= T_E_RISE) && (cnt < T_E_FALL);
				end
			end
			default: begin
				p = '0;
			end
		endcase
		return p;
	endfunction

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q + 1'b1;
		armed_d = armed_q;
		word_d  = word_q;
		cmd_pop = 1'b0;
		case (state_q)
			ST_PWRUP: begin
				if (!armed_q) begin
					cnt_d   = '0;
					armed_d = init_start;
				end else if (cnt_q == T_PWR_END) begin
					state_d = ST_INIT;
					cnt_d   = '0;
				end
			end
			ST_INIT: begin
				if (cnt_q == T_INIT_END) begin
					state_d = ST_IDLE;
					cnt_d   = '0;
				end
			end
			ST_IDLE: begin
				cnt_d = '0;
				if (init_start) begin        // re-init with new options
					state_d = ST_PWRUP;
				end else if (cmd_valid) begin
					cmd_pop = 1'b1;
					word_d  = cmd_word;
					state_d = ST_XFER;
				end
			end
			ST_XFER: begin
				if (cnt_q == T_XFER_END) begin
					state_d = ST_IDLE;
					cnt_d   = '0;
				end
			end
			default: begin
				state_d = ST_PWRUP;
			end
		endcase
		pins_d = decode(state_d, cnt_d, opts, word_d);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_PWRUP;
			cnt_q   <= '0;
			armed_q <= 1'b0;
			pins    <= '0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			armed_q <= armed_d;
			pins    <= pins_d;             // registered, no glitches on e
		end
	end

	always_ff @(posedge clk) begin
		word_q <= word_d;
	end

	assign init_done = (state_q == ST_IDLE) || (state_q == ST_XFER);
	assign busy      = (state_q == ST_PWRUP && armed_q) || (state_q == ST_INIT) ||
		(state_q == ST_XFER);

	// whole transfer window is busy, then at least one idle cycle
	a_busy_xfer: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_pop |=> busy [*XFER_LEN] ##1 !busy);

endmodule

`default_nettype wire

//--- hw/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	// one word as the display sees it
	typedef struct packed {
		logic       rs;      // register select
		logic       rw;      // read/write, passed to pin only
		logic [7:0] data;
	} lcd_word_t;

	typedef struct packed {
		logic lines;         // N bit of function set
		logic font;          // F bit of function set
		logic disp_on;
		logic cursor;
		logic blink;
		logic inc;           // I/D of entry mode
		logic shift;         // S of entry mode
	} lcd_opts_t;

	// host write word, decoded per target register
	typedef union packed {
		struct packed {
			logic [23:0] pad;
			logic        start;   // kicks off power-up and init
			lcd_opts_t   opts;
		} cfg;
		struct packed {
			logic [21:0] pad;
			lcd_word_t   word;
		} cmd;
	} lcd_wdata_u;

	typedef enum logic [1:0] {
		REG_CFG    = 2'd0,
		REG_CMD    = 2'd1,
		REG_STATUS = 2'd2
	} lcd_reg_e;

	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;    // byte address, word select in [3:2]
		logic [31:0] dat;
	} wb_req_t;

endpackage

`default_nettype wire

//--- hw/lcd_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_top (
	input  logic               clk,
	input  logic               arst_n,
	input  lcd_pkg::wb_req_t   wb_req,
	output logic [31:0]        wb_dat_o,
	output logic               wb_ack,
	output lcd_pkg::lcd_pins_t pins
);
	import lcd_pkg::*;

	lcd_opts_t                opts;
	logic                     init_start;
	logic                     push;
	lcd_word_t                push_word;
	logic                     fifo_full;
	logic [`LCD_LVL_BITS-1:0] fifo_level;
	logic                     cmd_valid;
	lcd_word_t                cmd_word;
	logic                     cmd_pop;
	logic                     init_done;
	logic                     busy;

	lcd_wb_regs u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_req     (wb_req),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack),
		.opts       (opts),
		.init_start (init_start),
		.push       (push),
		.push_word  (push_word),
		.fifo_full  (fifo_full),
		.fifo_level (fifo_level),
		.init_done  (init_done),
		.busy       (busy)
	);

	lcd_cmd_fifo u_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_word (push_word),
		.pop       (cmd_pop),
		.head      (cmd_word),
		.valid     (cmd_valid),
		.full      (fifo_full),
		.level     (fifo_level)
	);

	lcd_engine u_engine (
		.clk        (clk),
		.arst_n     (arst_n),
		.opts       (opts),
		.init_start (init_start),
		.cmd_valid  (cmd_valid),
		.cmd_word   (cmd_word),
		.cmd_pop    (cmd_pop),
		.init_done  (init_done),
		.busy       (busy),
		.pins       (pins)
	);

endmodule

`default_nettype wire

//--- hw/lcd_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_wb_regs (
	input  logic                         clk,
	input  logic                         arst_n,
	input  lcd_pkg::wb_req_t             wb_req,
	output logic [31:0]                  wb_dat_o,
	output logic                         wb_ack,
	output lcd_pkg::lcd_opts_t           opts,
	output logic                         init_start,
	output logic                         push,
	output lcd_pkg::lcd_word_t           push_word,
	input  logic                         fifo_full,
	input  logic [`LCD_LVL_BITS-1:0]     fifo_level,
	input  logic                         init_done,
	input  logic                         busy
);
	import lcd_pkg::*;

	lcd_wdata_u wdata;
	lcd_reg_e   sel;
	logic       req;       // request seen, not yet acked
	logic       stall;     // CMD write against a full queue
	logic       take;      // request served this cycle
	logic       wr_cfg;
	logic       wr_cmd;

	assign wdata = wb_req.dat;
	assign sel   = lcd_reg_e'(wb_req.adr[3:2]);
	assign req   = wb_req.cyc & wb_req.stb & ~wb_ack;

	assign stall  = wb_req.we & (sel == REG_CMD) & fifo_full;
	assign take   = req & ~stall;
	assign wr_cfg = take & wb_req.we & (sel == REG_CFG);
	assign wr_cmd = take & wb_req.we & (sel == REG_CMD);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack     <= 1'b0;
			init_start <= 1'b0;
			push       <= 1'b0;
			opts       <= '0;
		end else begin
			wb_ack     <= take;
			init_start <= wr_cfg & wdata.cfg.start;
			push       <= wr_cmd;           // lands with ack
			if (wr_cfg) begin
				opts <= wdata.cfg.opts;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_cmd) begin
			push_word <= wdata.cmd.word;
		end
	end

	// read mux, sampled by the master together with ack
	always_comb begin
		wb_dat_o = '0;
		case (sel)
			REG_CFG: begin
				wb_dat_o[$bits(lcd_opts_t)-1:0] = opts;
			end
			REG_STATUS: begin
				wb_dat_o[`LCD_STAT_DONE_BIT] = init_done;
				wb_dat_o[`LCD_STAT_BUSY_BIT] = busy;
				wb_dat_o[`LCD_STAT_LVL_LSB +: `LCD_LVL_BITS] = fifo_level;
			end
			default: begin
				wb_dat_o = '0;     // CMD is write only
			end
		endcase
	end

	// ack only answers a strobe the master still holds
	a_ack_held: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |-> wb_req.cyc && wb_req.stb);

	// full flag comes from the queue, push decided a cycle earlier
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> !fifo_full);

endmodule

`default_nettype wire

//--- include/lcd_cfg.svh
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// clocks per timing unit, 1 keeps simulation short
`define LCD_CLK_PER_US 1

// engine delay counter, must hold 500 * LCD_CLK_PER_US
`define LCD_CNT_BITS 10

// command queue depth, power of two
`define LCD_FIFO_DEPTH 8

// fill level width, counts 0 to depth
`define LCD_LVL_BITS ($clog2(`LCD_FIFO_DEPTH) + 1)

// STATUS register field positions
`define LCD_STAT_DONE_BIT 0
`define LCD_STAT_BUSY_BIT 1
`define LCD_STAT_LVL_LSB 8

`endif

//--- tests/lcd_pin_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_pin_checker (
	input logic               clk,
	input logic               arst_n,
	input lcd_pkg::lcd_pins_t pins
);
	import lcd_pkg::*;

	lcd_pins_t exp_q[$];       // filled by the testbench in write order
	lcd_pins_t held;           // last pin image with e high
	logic      e_q;
	int        err_cnt = 0;
	int        strobe_cnt = 0;

	task automatic add_expected(input lcd_pins_t p);
		exp_q.push_back(p);
	endtask

	task automatic compare_strobe(input lcd_pins_t got);
		lcd_pins_t exp;
		strobe_cnt++;
		if (exp_q.size() == 0) begin
			$display("unexpected strobe at %0t ns with no word queued", $time);
			err_cnt++;
			return;
		end
		exp = exp_q.pop_front();
		if (got.rs !== exp.rs) begin
			$display("FAILED pins.rs expected %h got %h", exp.rs, got.rs);
			err_cnt++;
		end
		if (got.rw !== exp.rw) begin
			$display("FAILED pins.rw expected %h got %h", exp.rw, got.rw);
			err_cnt++;
		end
		if (got.data !== exp.data) begin
			$display("FAILED pins.data expected %h got %h", exp.data, got.data);
			err_cnt++;
		end
	endtask

	task automatic report_leftover();
		lcd_pins_t exp;
		while (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			$display("missing strobe: rs %h rw %h data %h never reached the pins",
				exp.rs, exp.rw, exp.data);
			err_cnt++;
		end
	endtask

	// pins are registered, so the posedge view is settled
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_q  <= 1'b0;
			held <= '0;
		end else begin
			e_q <= pins.e;
			if (pins.e) begin
				held <= pins;
			end
			if (e_q && !pins.e) begin   // falling edge of e
				compare_strobe(held);
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_lcd.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module tb_lcd;
	import lcd_pkg::*;

	localparam int ACK_TIMEOUT = 2000;     // cycles per bus access
	localparam int POLL_LIMIT  = 1000;     // status reads per wait
	localparam int BURST_LEN   = `LCD_FIFO_DEPTH + 4;

	logic        clk;
	logic        arst_n;
	wb_req_t     wb_req;
	logic [31:0] wb_dat_o;
	logic        wb_ack;
	lcd_pins_t   pins;

	int          err_cnt;
	int          cmd_sent;      // acked CMD writes
	int          ack_wait;      // cycles of the last access
	int          max_wait;
	int          total;
	bit          timed_out;
	lcd_opts_t   opts;
	logic [31:0] rnd;
	logic [31:0] cfg_rd;
	logic        st_done;
	logic        st_busy;
	int          st_level;

	lcd_top u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_req   (wb_req),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.pins     (pins)
	);

	lcd_pin_checker u_chk (
		.clk    (clk),
		.arst_n (arst_n),
		.pins   (pins)
	);

	always #50 clk = ~clk;

	// steps 0 to 3 are the init instructions, anything else a CMD word
	function automatic lcd_pins_t expected_pins(int step, lcd_opts_t o, lcd_word_t w);
		lcd_pins_t p;
		p   = '0;
		p.e = 1'b1;
		case (step)
			0: p.data = {4'b0011, o.lines, o.font, 2'b00};
			1: p.data = {5'b00001, o.disp_on, o.cursor, o.blink};
			2: p.data = 8'h01;
			3: p.data = {6'b000001, o.inc, o.shift};
			default: begin
				p.rs   = w.rs;
				p.rw   = w.rw;
				p.data = w.data;
			end
		endcase
		return p;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, got);
			err_cnt++;
		end
	endtask

	// called and returns a little after a rising edge
	task automatic wb_cycle(input bit we, input lcd_reg_e sel, input logic [31:0] dat,
		output logic [31:0] rdat);
		int n;
		rdat = '0;
		if (timed_out) begin
			return;
		end
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = {sel, 2'b00};
		wb_req.dat = dat;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!wb_ack && n < ACK_TIMEOUT);
		ack_wait = n;
		if (!wb_ack) begin
			$display("timeout: no ack on register %0d after %0d cycles", sel, n);
			timed_out = 1'b1;
			err_cnt++;
			wb_req = '0;
			return;
		end
		rdat = wb_dat_o;
		@(posedge clk);
		#1;
		wb_req = '0;                    // stb drops the cycle after ack
	endtask

	task automatic write_cfg(input lcd_opts_t o, input bit start);
		lcd_wdata_u  w;
		logic [31:0] unused;
		w = '0;
		w.cfg.start = start;
		w.cfg.opts  = o;
		wb_cycle(1'b1, REG_CFG, w, unused);
	endtask

	task automatic write_random_cmd();
		lcd_wdata_u  w;
		logic [31:0] unused;
		w = '0;
		rnd = $urandom;
		w.cmd.word = rnd[9:0];
		u_chk.add_expected(expected_pins(-1, opts, w.cmd.word));
		wb_cycle(1'b1, REG_CMD, w, unused);
		if (!timed_out) begin
			cmd_sent++;
		end
	endtask

	// level may lag by the one word the engine holds
	task automatic read_status();
		logic [31:0] r;
		int hi;
		wb_cycle(1'b0, REG_STATUS, '0, r);
		st_done  = r[`LCD_STAT_DONE_BIT];
		st_busy  = r[`LCD_STAT_BUSY_BIT];
		st_level = r[`LCD_STAT_LVL_LSB +: `LCD_LVL_BITS];
		if (st_done && !timed_out) begin
			hi = cmd_sent - (u_chk.strobe_cnt - 4);
			if (st_level > hi || st_level < hi - 1) begin
				$display("FAILED status.level expected %h or %h got %h", hi - 1, hi, st_level);
				err_cnt++;
			end
		end
	endtask

	task automatic wait_status(input bit want_idle);
		int n;
		n = 0;
		do begin
			read_status();
			n++;
		end while (!timed_out && n < POLL_LIMIT &&
			!(st_done && (!want_idle || (!st_busy && st_level == 0))));
		if (!timed_out && n >= POLL_LIMIT) begin
			$display("timeout: controller not %s after %0d status reads",
				want_idle ? "idle" : "initialized", n);
			timed_out = 1'b1;
			err_cnt++;
		end
	endtask

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		wb_req    = '0;
		err_cnt   = 0;
		cmd_sent  = 0;
		max_wait  = 0;
		timed_out = 1'b0;
		opts      = '0;
		rnd       = $urandom(32'h2b228ff4);
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// quiet bus after reset, options alone do not start init
		repeat (20) begin
			@(negedge clk);
			check_field("pins.e", 0, pins.e);
			check_field("pins.data", 0, pins.data);
		end
		@(posedge clk);
		#1;
		rnd  = $urandom;
		opts = rnd[6:0];
		write_cfg(opts, 1'b0);
		wb_cycle(1'b0, REG_CFG, '0, cfg_rd);
		check_field("cfg.opts", {25'd0, opts}, cfg_rd);
		read_status();
		check_field("status.init_done", 0, st_done);
		check_field("status.busy", 0, st_busy);

		// init with random options, words queued before it ends
		for (int i = 0; i < 4; i++) begin
			u_chk.add_expected(expected_pins(i, opts, '0));
		end
		write_cfg(opts, 1'b1);
		for (int i = 0; i < 3; i++) begin
			write_random_cmd();
		end
		wait_status(1'b0);
		if (!timed_out && u_chk.strobe_cnt < 4) begin
			$display("init_done reported before all four init strobes were seen");
			err_cnt++;
		end
		wait_status(1'b1);

		for (int i = 0; i < 6; i++) begin
			write_random_cmd();
			wait_status(1'b1);
		end

		write_random_cmd();
		read_status();
		check_field("status.busy", 1, st_busy);
		wait_status(1'b1);

		// overfill the queue, acks must stall
		for (int i = 0; i < BURST_LEN; i++) begin
			write_random_cmd();
			if (ack_wait > max_wait) begin
				max_wait = ack_wait;
			end
		end
		if (!timed_out && max_wait <= 1) begin
			$display("burst of CMD writes never saw ack held off by a full queue");
			err_cnt++;
		end
		wait_status(1'b1);

		u_chk.report_leftover();
		total = err_cnt + u_chk.err_cnt;
		$display("errors: %0d bus and status, %0d pins, %0d total", err_cnt, u_chk.err_cnt,
			total);
		if (total == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
